// File: sim.f
logic/cpuPkg.sv
logic/fetchUnit.sv
logic/controlUnit.sv
logic/regFile.sv
logic/execUnit.sv
logic/cpu.sv
sim/cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f sim.f

if ./obj_dir/VcpuTb | tee /dev/stderr | grep -q "Everything OK"; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: sim/cpuTb.sv
`default_nettype none

module cpuTb;

  localparam int romDepth = 256;
  localparam int period   = 40;

  logic            clk;
  logic            arstN;
  cpuPkg::instrT   instr;
  cpuPkg::wordT    pc;
  logic            hlt;
  cpuPkg::wbT      wb;

  logic [15:0]     rom [romDepth];          // Program, one word per instruction
  int              progLen;
  integer          seed;
  cpuPkg::regAddrT expRd [romDepth];        // Model writebacks in retire order
  cpuPkg::wordT    expData [romDepth];
  cpuPkg::wordT    jumpTarget [romDepth];   // Model taken-branch targets
  int              expCount, jumpCount;
  int              wbIdx = 0;
  int              jumpIdx = 0;
  int              cyc = 0;
  cpuPkg::wordT    prevPc;                  // pc of the previous cycle
  logic            hltSeen = 1'b0;
  logic            jumped;
  cpuPkg::regAddrT expRdNow;
  cpuPkg::wordT    expDataNow, expJumpNow;

  cpu dut_i (.clk, .arstN, .instr, .pc, .hlt, .wb);

  assign instr      = rom[pc[8:1]];  // Instruction memory answers in the same cycle
  assign expRdNow   = expRd[wbIdx[7:0]];
  assign expDataNow = expData[wbIdx[7:0]];
  assign expJumpNow = jumpTarget[jumpIdx[7:0]];
  // Neither a hold nor a step, so a redirect
  assign jumped     = arstN && pc != prevPc && pc != prevPc + 16'd2;

  always #(period / 2) clk = ~clk;

  ////////////////////
  // Failure reporting
  ////////////////////
  task automatic abortRun();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic plainFailure(input string msg);
    $display("%s at time %0t", msg, $time);
    abortRun();
  endtask

  task automatic checkFailed(input string name, input logic [31:0] expVal,
                             input logic [31:0] gotVal);
    $display("CHECK FAILED time %0t %s expected %0h got %0h", $time, name, expVal, gotVal);
    abortRun();
  endtask

  ////////////////////
  // Program
  ////////////////////
  function automatic logic [15:0] regInstr(input logic [3:0] op, rd, rs, rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] branchInstr(input logic [2:0] cond, input logic [8:0] off);
    return {cpuPkg::opBranch, cond, off};
  endfunction

  task automatic putWord(input logic [15:0] w);
    rom[progLen[7:0]] = w;
    progLen++;
  endtask

  // Flag setter, branch over two fillers
  task automatic condPair(input logic [15:0] setter, input logic [2:0] cond);
    putWord(setter);
    putWord(branchInstr(cond, 9'd2));
    putWord(regInstr(cpuPkg::opAddi, 4'd14, 4'd14, 4'd1));
    putWord(regInstr(cpuPkg::opAddi, 4'd15, 4'd15, 4'd2));
  endtask

  task automatic buildProgram();
    logic [31:0] r;
    logic [15:0] setA, setB, setC, setD;
    setA = regInstr(cpuPkg::opAddi, 4'd11, 4'd0, 4'd3);   // +3, flags clear
    setB = regInstr(cpuPkg::opSub, 4'd12, 4'd1, 4'd1);    // Zero
    setC = regInstr(cpuPkg::opAddi, 4'd13, 4'd0, 4'hE);   // Negative
    setD = regInstr(cpuPkg::opAdd, 4'd4, 4'd4, 4'd4);     // 8000 + 8000 overflows
    for (int i = 0; i < romDepth; i++) rom[8'(i)] = {4'h4, 12'(i)};  // NOP tagged with its address
    progLen = 0;
    putWord(regInstr(cpuPkg::opAddi, 4'd1, 4'd0, 4'd1));
    putWord(regInstr(cpuPkg::opAddi, 4'd0, 4'd1, 4'd5));  // Dropped write to r0
    putWord(regInstr(cpuPkg::opAdd, 4'd9, 4'd0, 4'd1));   // Reads r0 as zero
    putWord(regInstr(cpuPkg::opAddi, 4'd4, 4'd0, 4'h8));
    for (int i = 0; i < 13; i++) putWord(setD);          // Dependent chain down to 8000
    putWord(regInstr(cpuPkg::opSub, 4'd5, 4'd0, 4'd4));   // Positive rail
    putWord(regInstr(cpuPkg::opAdd, 4'd6, 4'd5, 4'd5));
    putWord(regInstr(cpuPkg::opXor, 4'd7, 4'd5, 4'd4));
    putWord(regInstr(cpuPkg::opXor, 4'd8, 4'd7, 4'd7));
    putWord(regInstr(cpuPkg::opSub, 4'd10, 4'd9, 4'd7));
    condPair(setA, cpuPkg::condNe);
    condPair(setB, cpuPkg::condNe);
    condPair(setB, cpuPkg::condEq);
    condPair(setA, cpuPkg::condEq);
    condPair(setA, cpuPkg::condGt);
    condPair(setB, cpuPkg::condGt);
    condPair(setC, cpuPkg::condLt);
    condPair(setA, cpuPkg::condLt);
    condPair(setA, cpuPkg::condGe);
    condPair(setC, cpuPkg::condGe);
    condPair(setC, cpuPkg::condLe);
    condPair(setA, cpuPkg::condLe);
    condPair(setD, cpuPkg::condOv);
    condPair(setA, cpuPkg::condOv);
    condPair(setA, cpuPkg::condAl);
    // Random block, branches forward by 2 to 5
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      if (r[2:0] >= 3'd6) putWord(branchInstr(r[5:3], {7'd0, r[7:6]} + 9'd2));
      else putWord(regInstr({2'b00, r[9:8]}, r[13:10], r[17:14], r[21:18]));
    end
    for (int i = 0; i < 6; i++) putWord(regInstr(cpuPkg::opAddi, 4'd14, 4'd14, 4'd1));
    putWord({cpuPkg::opHalt, 12'd0});
    putWord(regInstr(cpuPkg::opAddi, 4'd15, 4'd15, 4'd1));  // Must never retire
  endtask

  ////////////////////
  // ISA reference model
  ////////////////////
  function automatic logic [16:0] satResult(input int s);
    if (s > 32767) return {1'b1, 16'h7FFF};
    if (s < -32768) return {1'b1, 16'h8000};
    return {1'b0, s[15:0]};
  endfunction

  function automatic logic condHolds(input logic [2:0] cond, input logic z, n, v);
    case (cond)
      cpuPkg::condNe: return !z;
      cpuPkg::condEq: return z;
      cpuPkg::condGt: return !z && !n;
      cpuPkg::condLt: return n;
      cpuPkg::condGe: return z || !n;
      cpuPkg::condLe: return n || z;
      cpuPkg::condOv: return v;
      default:        return 1'b1;
    endcase
  endfunction

  task automatic runModel();
    cpuPkg::wordT mregs [16];
    cpuPkg::wordT a, b, res;
    logic [15:0]  w;
    logic [16:0]  sat;
    logic         z, n, v, done, wr;
    int           mpc, sa, sb, off;
    foreach (mregs[i]) mregs[i] = '0;
    z = 1'b0;
    n = 1'b0;
    v = 1'b0;
    done = 1'b0;
    mpc = 0;
    expCount = 0;
    jumpCount = 0;
    while (!done && mpc < progLen) begin
      w   = rom[mpc[7:0]];
      a   = mregs[w[7:4]];
      b   = (w[15:12] == cpuPkg::opAddi) ? {{12{w[3]}}, w[3:0]} : mregs[w[3:0]];
      sa  = $signed(a);
      sb  = $signed(b);
      wr  = 1'b0;
      res = '0;
      mpc = mpc + 1;
      case (w[15:12])
        cpuPkg::opAdd, cpuPkg::opAddi, cpuPkg::opSub: begin
          sat = (w[15:12] == cpuPkg::opSub) ? satResult(sa - sb) : satResult(sa + sb);
          res = sat[15:0];
          v   = sat[16];
          n   = res[15];
          z   = (res == '0);  // Flags update even when rd is r0
          wr  = 1'b1;
        end
        cpuPkg::opXor: begin
          res = a ^ b;
          z   = (res == '0);  // N and V keep their value
          wr  = 1'b1;
        end
        cpuPkg::opBranch: if (condHolds(w[11:9], z, n, v)) begin
          off = $signed(w[8:0]);
          mpc = mpc + off;
          jumpTarget[jumpCount[7:0]] = 16'(mpc * 2);
          jumpCount++;
        end
        cpuPkg::opHalt: done = 1'b1;
        default: ;
      endcase
      if (wr && w[11:8] != 4'd0) begin
        mregs[w[11:8]] = res;
        expRd[expCount[7:0]] = w[11:8];
        expData[expCount[7:0]] = res;
        expCount++;
      end
    end
  endtask

  ////////////////////
  // Progress tracking
  ////////////////////
  always @(posedge clk) begin
    cyc    <= cyc + 1;
    prevPc <= pc;
    if (wb.valid === 1'b1) wbIdx <= wbIdx + 1;
    if (jumped === 1'b1) jumpIdx <= jumpIdx + 1;
    if (hlt === 1'b1) hltSeen <= 1'b1;
  end

  ////////////////////
  // Checks
  ////////////////////
  resetPcA: assert property (@(posedge clk) ((!arstN && cyc > 0) || $rose(arstN)) |-> pc == '0)
    else checkFailed("pc", 32'd0, 32'($sampled(pc)));
  resetHltA: assert property (@(posedge clk) ((!arstN && cyc > 0) || $rose(arstN)) |-> !hlt)
    else checkFailed("hlt", 32'd0, 32'($sampled(hlt)));
  resetWbA: assert property (@(posedge clk) ((!arstN && cyc > 0) || $rose(arstN)) |-> !wb.valid)
    else checkFailed("wb.valid", 32'd0, 32'($sampled(wb.valid)));

  wbCountA: assert property (@(posedge clk) wb.valid |-> wbIdx < expCount)
    else plainFailure("Writeback beyond the end of the model sequence");
  wbRdA: assert property (@(posedge clk) (wb.valid && wbIdx < expCount) |-> wb.rd == expRdNow)
    else checkFailed("wb.rd", 32'($sampled(expRdNow)), 32'($sampled(wb.rd)));
  wbDataA: assert property (@(posedge clk)
    (wb.valid && wbIdx < expCount) |-> wb.data == expDataNow)
    else checkFailed("wb.data", 32'($sampled(expDataNow)), 32'($sampled(wb.data)));
  wbR0A: assert property (@(posedge clk) wb.valid |-> wb.rd != '0)
    else plainFailure("Writeback targets register 0");

  jumpCountA: assert property (@(posedge clk) jumped |-> jumpIdx < jumpCount)
    else plainFailure("pc jumped where the model takes no branch");
  jumpPcA: assert property (@(posedge clk) (jumped && jumpIdx < jumpCount) |-> pc == expJumpNow)
    else checkFailed("pc", 32'($sampled(expJumpNow)), 32'($sampled(pc)));

  // All retirements done once hlt rises
  doneWbA: assert property (@(posedge clk) $rose(hlt) |-> wbIdx == expCount)
    else checkFailed("writeback count", $sampled(expCount), $sampled(wbIdx));
  doneJumpA: assert property (@(posedge clk) $rose(hlt) |-> jumpIdx == jumpCount)
    else checkFailed("taken branch count", $sampled(jumpCount), $sampled(jumpIdx));
  hltStickyA: assert property (@(posedge clk) hltSeen |-> hlt)
    else plainFailure("hlt dropped after rising");
  pcFrozenA: assert property (@(posedge clk) hlt |-> pc == prevPc)
    else checkFailed("pc", 32'($sampled(prevPc)), 32'($sampled(pc)));
  hltNoWbA: assert property (@(posedge clk) hlt |-> !wb.valid)
    else checkFailed("wb.valid", 32'd0, 32'($sampled(wb.valid)));

  ////////////////////
  // Run control
  ////////////////////
  initial begin
    clk   = 1'b0;
    arstN = 1'b0;
    seed  = 32'hf16b4840;
    buildProgram();
    runModel();
    repeat (16) @(posedge clk);
    #2 arstN = 1'b1;  // Release just after the edge
    wait (hlt === 1'b1);
    repeat (4) @(posedge clk);  // Let the post-halt checks see a few cycles
    $display("Everything OK");
    $finish;
  end

  // Worst case per instruction is a stall, a flush and itself
  initial begin
    @(posedge arstN);
    repeat (progLen * 3 + 40) @(posedge clk);
    plainFailure("Timeout waiting for hlt");
  end

endmodule

`default_nettype wire

// File: logic/cpu.sv
`default_nettype none

module cpu (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire cpuPkg::instrT  instr,   // Instruction at pc, same cycle
  output wire cpuPkg::wordT   pc,
  output wire                 hlt,
  output wire cpuPkg::wbT     wb       // Writeback trace
);

  ////////////////////
  // Stage wiring
  ////////////////////
  wire cpuPkg::instrT   idInstr;       // IF/ID instruction
  wire cpuPkg::wordT    idPc;          // IF/ID pc
  wire                  stall;
  wire                  redirect;
  wire cpuPkg::wordT    branchTarget;
  wire cpuPkg::regAddrT rs, rt;        // Read addresses from decode
  wire cpuPkg::wordT    rsData, rtData;
  wire cpuPkg::ctrlT    ctrl;          // Decoded control into ID/EX
  wire cpuPkg::ctrlT    exCtrl;        // Control now in EX
  wire cpuPkg::wordT    imm;
  wire cpuPkg::flagsT   flags;
  wire                  halted;

  fetchUnit fetch_i (
    .clk, .arstN, .instr, .stall, .redirect, .branchTarget,
    .pc, .idInstr, .idPc
  );

  controlUnit control_i (
    .clk, .arstN, .idInstr, .idPc, .flags, .exCtrl,
    .rs, .rt, .ctrl, .imm, .stall, .redirect, .branchTarget, .halted
  );

  regFile regs_i (
    .clk, .arstN, .rs, .rt, .wb, .rsData, .rtData
  );

  execUnit exec_i (
    .clk, .arstN, .ctrl, .imm, .rsData, .rtData, .halted,
    .exCtrl, .flags, .wb, .hlt
  );

endmodule

`default_nettype wire

// File: logic/execUnit.sv
`default_nettype none

module execUnit (
  input  wire                  clk,
  input  wire                  arstN,
  input  wire cpuPkg::ctrlT    ctrl,
  input  wire cpuPkg::wordT    imm,
  input  wire cpuPkg::wordT    rsData,
  input  wire cpuPkg::wordT    rtData,
  input  wire                  halted,     // Halt latch from decode
  output cpuPkg::ctrlT         exCtrl,     // ID/EX control, also for the flag hazard
  output cpuPkg::flagsT        flags,
  output cpuPkg::wbT           wb,
  output logic                 hlt
);

  localparam int msb = cpuPkg::wordW - 1;

  typedef struct packed {
    cpuPkg::wordT imm;
    cpuPkg::wordT a;
    cpuPkg::wordT b;
  } operandsT;

  operandsT     exOps;
  cpuPkg::wordT opB;
  cpuPkg::wordT addRes, subRes;
  cpuPkg::wordT satVal;
  cpuPkg::wordT result;
  logic         addOv, subOv;
  logic         overflow;

  ////////////////////
  // ID/EX register
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) exCtrl <= '0;  // Bubble
    else exCtrl <= ctrl;
  end

  always_ff @(posedge clk) begin
    exOps <= '{imm: imm, a: rsData, b: rtData};
  end

  ////////////////////
  // Saturating ALU
  ////////////////////
  always_comb begin
    opB    = exCtrl.useImm ? exOps.imm : exOps.b;
    addRes = exOps.a + opB;
    subRes = exOps.a - opB;
    addOv  = (exOps.a[msb] == opB[msb]) && (addRes[msb] != exOps.a[msb]);  // Like signs flip
    subOv  = (exOps.a[msb] != opB[msb]) && (subRes[msb] != exOps.a[msb]);
    satVal = exOps.a[msb] ? 16'h8000 : 16'h7FFF;  // Sign of a picks the rail
    case (exCtrl.aluOp)
      cpuPkg::aluSub: begin
        overflow = subOv;
        result   = subOv ? satVal : subRes;
      end
      cpuPkg::aluXor: begin
        overflow = 1'b0;
        result   = exOps.a ^ opB;
      end
      default: begin
        overflow = addOv;
        result   = addOv ? satVal : addRes;
      end
    endcase
  end

  assign wb = '{valid: exCtrl.regWrite, rd: exCtrl.rd, data: result};

  // Flag register and halt
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
      hlt   <= 1'b0;
    end else begin
      if (exCtrl.setZ) flags.z <= (result == '0);
      if (exCtrl.setNv) begin
        flags.n <= result[msb];
        flags.v <= overflow;
      end
      if (exCtrl.halt && halted) hlt <= 1'b1;  // Sticky until reset
    end
  end

  // Decode strips writes to r0
  noWbR0_a: assert property (@(posedge clk) disable iff (!arstN)
    wb.valid |-> wb.rd != '0);

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none

module regFile (
  input  wire                    clk,
  input  wire                    arstN,
  input  wire cpuPkg::regAddrT   rs,
  input  wire cpuPkg::regAddrT   rt,
  input  wire cpuPkg::wbT        wb,      // Writeback from EX
  output cpuPkg::wordT           rsData,
  output cpuPkg::wordT           rtData
);

  cpuPkg::wordT regs [16];

  // One read port with the same-edge bypass
  function automatic cpuPkg::wordT readPort(input cpuPkg::regAddrT addr);
    if (addr == '0) readPort = '0;                              // Hard-wired zero
    else if (wb.valid && wb.rd == addr) readPort = wb.data;    // Bypass EX result
    else readPort = regs[addr];
  endfunction

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 16; i++) regs[i] <= '0;
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////
  always_comb begin
    rsData = readPort(rs);
    rtData = readPort(rt);
  end

endmodule

`default_nettype wire

// File: logic/controlUnit.sv
`default_nettype none

module controlUnit (
  input  wire                   clk,
  input  wire                   arstN,
  input  wire cpuPkg::instrT    idInstr,
  input  wire cpuPkg::wordT     idPc,
  input  wire cpuPkg::flagsT    flags,         // Committed flags
  input  wire cpuPkg::ctrlT     exCtrl,        // Instruction in EX
  output cpuPkg::regAddrT       rs,
  output cpuPkg::regAddrT       rt,
  output cpuPkg::ctrlT          ctrl,
  output cpuPkg::wordT          imm,
  output logic                  stall,
  output logic                  redirect,
  output cpuPkg::wordT          branchTarget,
  output logic                  halted         // Latched once HLT is decoded
);

  cpuPkg::ctrlT dec;
  cpuPkg::wordT seqPc;         // Address after the ID instruction
  cpuPkg::wordT branchOffset;  // Sign-extended byte offset
  logic         isBranch;
  logic         isHalt;
  logic         flagHazard;
  logic         taken;

  // Branch condition against the flag register
  function automatic logic condMet(input logic [2:0] cond, input cpuPkg::flagsT f);
    case (cond)
      cpuPkg::condNe: condMet = !f.z;
      cpuPkg::condEq: condMet = f.z;
      cpuPkg::condGt: condMet = !f.z && !f.n;
      cpuPkg::condLt: condMet = f.n;
      cpuPkg::condGe: condMet = f.z || !f.n;
      cpuPkg::condLe: condMet = f.n || f.z;
      cpuPkg::condOv: condMet = f.v;
      default:        condMet = 1'b1;  // condAl
    endcase
  endfunction

  ////////////////////
  // Decode
  ////////////////////
  assign rs  = idInstr.rView.rs;
  assign rt  = idInstr.rView.rt;
  assign imm = {{(cpuPkg::wordW - cpuPkg::regAddrW){idInstr.rView.rt[3]}}, idInstr.rView.rt};

  always_comb begin
    dec = '0;  // Unknown opcodes fall out as NOP
    case (idInstr.rView.opcode)
      cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAddi: begin
        dec.regWrite = 1'b1;
        dec.aluOp    = (idInstr.rView.opcode == cpuPkg::opSub) ? cpuPkg::aluSub : cpuPkg::aluAdd;
        dec.useImm   = (idInstr.rView.opcode == cpuPkg::opAddi);
        dec.setZ     = 1'b1;
        dec.setNv    = 1'b1;
        dec.rd       = idInstr.rView.rd;
      end
      cpuPkg::opXor: begin
        dec.regWrite = 1'b1;
        dec.aluOp    = cpuPkg::aluXor;
        dec.setZ     = 1'b1;  // Z only
        dec.rd       = idInstr.rView.rd;
      end
      cpuPkg::opHalt: dec.halt = 1'b1;
      default: ;
    endcase
    if (dec.rd == '0) dec.regWrite = 1'b0;  // r0 is hard-wired
  end

  ////////////////////
  // Branch and hazards
  ////////////////////
  assign isBranch     = (idInstr.bView.opcode == cpuPkg::opBranch);
  assign isHalt       = (idInstr.rView.opcode == cpuPkg::opHalt);
  assign flagHazard   = isBranch && (exCtrl.setZ || exCtrl.setNv);  // Flags not yet committed
  assign taken        = isBranch && !flagHazard && condMet(idInstr.bView.cond, flags);
  assign seqPc        = idPc + cpuPkg::pcStep;
  assign branchOffset = {{(cpuPkg::wordW - 10){idInstr.bView.offset[8]}},
                         idInstr.bView.offset, 1'b0};

  // HLT reuses the redirect path to hold pc at seqPc and bubble IF/ID
  assign branchTarget = isBranch ? seqPc + branchOffset : seqPc;
  assign stall        = flagHazard || halted;
  assign redirect     = taken || isHalt;
  assign ctrl         = stall ? '0 : dec;  // Bubble into ID/EX

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) halted <= 1'b0;
    else if (isHalt) halted <= 1'b1;  // Sticky until reset
  end

  // Once halted, IF/ID must only hold bubbles
  stallRedirect_a: assert property (@(posedge clk) disable iff (!arstN)
    !(stall && redirect));

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
`default_nettype none

module fetchUnit (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire cpuPkg::instrT  instr,
  input  wire                 stall,         // Hold pc and IF/ID
  input  wire                 redirect,      // Load target, bubble IF/ID
  input  wire cpuPkg::wordT   branchTarget,
  output cpuPkg::wordT        pc,
  output cpuPkg::instrT       idInstr,
  output cpuPkg::wordT        idPc
);

  cpuPkg::wordT pcNext;

  ////////////////////
  // Next pc
  ////////////////////
  always_comb begin
    if (redirect) pcNext = branchTarget;        // Taken branch or halt
    else if (stall) pcNext = pc;                // Flag hazard or halted
    else pcNext = pc + cpuPkg::pcStep;          // Predict not taken
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) pc <= '0;
    else pc <= pcNext;
  end

  ////////////////////
  // IF/ID register
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idInstr <= cpuPkg::nopInstr;  // Start with a bubble
      idPc    <= '0;
    end else if (redirect) begin
      idInstr <= cpuPkg::nopInstr;  // Squash the wrong-path fetch
      idPc    <= pc;
    end else if (!stall) begin
      idInstr <= instr;
      idPc    <= pc;
    end
  end

  // Targets are pc plus even offsets, so bit 0 never sets
  pcEven_a: assert property (@(posedge clk) disable iff (!arstN) pc[0] == 1'b0);

endmodule

`default_nettype wire

// File: logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int wordW    = 16;  // Data and address width
  localparam int regAddrW = 4;   // Register index width

  typedef logic [wordW-1:0]    wordT;
  typedef logic [regAddrW-1:0] regAddrT;

  // Opcodes, top nibble of the instruction
  localparam logic [3:0] opAdd    = 4'd0;
  localparam logic [3:0] opSub    = 4'd1;
  localparam logic [3:0] opXor    = 4'd2;
  localparam logic [3:0] opAddi   = 4'd3;
  localparam logic [3:0] opBranch = 4'd12;
  localparam logic [3:0] opHalt   = 4'd15;

  // Branch condition codes
  localparam logic [2:0] condNe = 3'd0;  // Z clear
  localparam logic [2:0] condEq = 3'd1;  // Z set
  localparam logic [2:0] condGt = 3'd2;  // Z and N clear
  localparam logic [2:0] condLt = 3'd3;  // N set
  localparam logic [2:0] condGe = 3'd4;  // Z set or N clear
  localparam logic [2:0] condLe = 3'd5;  // N or Z set
  localparam logic [2:0] condOv = 3'd6;  // V set
  localparam logic [2:0] condAl = 3'd7;  // Unconditional

  localparam wordT pcStep = 16'd2;  // Byte address step per instruction

  ////////////////////
  // Instruction word
  ////////////////////
  typedef struct packed {
    logic [3:0] opcode;
    regAddrT    rd;
    regAddrT    rs;
    regAddrT    rt;  // Signed 4-bit immediate for ADDI
  } rViewT;

  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] cond;
    logic [8:0] offset;  // Signed, in instructions
  } bViewT;

  typedef union packed {
    rViewT rView;  // Register and ADDI form
    bViewT bView;  // Branch form
  } instrT;

  // Opcode 4 is unused, so this word decodes as a NOP
  localparam instrT nopInstr = 16'h4000;

  ////////////////////
  // Pipeline words
  ////////////////////
  typedef enum logic [1:0] {
    aluAdd = 2'd0,
    aluSub = 2'd1,
    aluXor = 2'd2
  } aluOpT;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

  // All zero is a bubble
  typedef struct packed {
    logic    regWrite;
    logic    useImm;   // Operand B from imm instead of rt
    aluOpT   aluOp;
    logic    setZ;
    logic    setNv;    // Update N and V
    logic    halt;
    regAddrT rd;
  } ctrlT;

  typedef struct packed {
    logic    valid;
    regAddrT rd;
    wordT    data;
  } wbT;

endpackage

`default_nettype wire
